// File: Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - ex_stage.sv
  - ex_mem.sv
  - data_ram.sv
  - mem_wb_stage.sv
  - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu.sv

// File: data_ram.sv
`default_nettype none

module data_ram (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              req_i,
    input  wire logic                              we_i,
    input  wire logic [lsu_pkg::bus_width-1:0]     addr_i,
    input  wire logic [lsu_pkg::data_width-1:0]    wdata_i,
    input  wire logic [lsu_pkg::f3_width-1:0]      funct3_i,
    output logic                                   addr_ok_o,
    output logic      [lsu_pkg::data_width-1:0]    rdata_o
);

    logic [lsu_pkg::data_width-1:0]     mem_q [lsu_pkg::ram_words];
    logic [lsu_pkg::bytes_per_word-1:0] byte_en;
    logic [lsu_pkg::bus_width-3:0]      word_addr;
    logic                               store_busy_q;
    logic                               accept;

    assign word_addr = addr_i[lsu_pkg::bus_width-1:2];
    assign accept = req_i && addr_ok_o;

    // one dead cycle after every write
    assign addr_ok_o = !store_busy_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            store_busy_q <= 1'b0;
        end
        else
        begin
            store_busy_q <= accept && we_i;
        end
    end

    // lane enables from size and low address bits
    always_comb
    begin
        case (funct3_i)
            lsu_pkg::f3_byte, lsu_pkg::f3_byte_u:
                byte_en = 4'b0001 << addr_i[1:0];
            lsu_pkg::f3_half, lsu_pkg::f3_half_u:
                byte_en = addr_i[1] ? 4'b1100 : 4'b0011;
            default:
                byte_en = 4'b1111;
        endcase
    end

    // read data stays until the next accepted read
    always_ff @(posedge clk)
    begin
        if (accept && we_i)
        begin
            for (int i = 0; i < lsu_pkg::bytes_per_word; i++)
            begin
                if (byte_en[i])
                begin
                    mem_q[word_addr][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
        else if (accept)
        begin
            rdata_o <= mem_q[word_addr];
        end
    end

endmodule

`default_nettype wire

// File: ex_mem.sv
`default_nettype none

module ex_mem (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              flush_i,
    input  wire logic                              hold_i,
    input  wire logic                              mem_addr_ok_i,
    input  wire logic                              allow_in_wb_i,
    input  wire logic                              valid_ex_i,
    input  wire logic [lsu_pkg::data_width-1:0]    mem_address_i,
    input  wire logic [lsu_pkg::data_width-1:0]    mem_write_data_i,
    input  wire logic [lsu_pkg::ctl_width-1:0]     control_flow_ex_i,
    input  wire logic [lsu_pkg::rd_width-1:0]      rd_ex_i,
    input  wire logic [lsu_pkg::f3_width-1:0]      funct3_i,
    output logic                                   ram_req_o,
    output logic      [lsu_pkg::bus_width-1:0]     mem_address_o,
    output logic      [lsu_pkg::data_width-1:0]    mem_write_data_o,
    output logic                                   mem_read_o,
    output logic                                   mem_write_o,
    output logic                                   regwrite_o,
    output logic      [lsu_pkg::rd_width-1:0]      rd_mem_o,
    output logic      [lsu_pkg::f3_width-1:0]      funct3_o,
    output logic                                   valid_mem_o,
    output logic                                   ready_go_mem_o,
    output logic                                   allow_in_mem_o
);

    logic                           valid_q;
    logic [lsu_pkg::data_width-1:0] address_q;
    logic [lsu_pkg::data_width-1:0] wdata_q;
    logic [lsu_pkg::ctl_width-1:0]  control_q;
    logic [lsu_pkg::rd_width-1:0]   rd_q;
    logic [lsu_pkg::f3_width-1:0]   funct3_q;
    logic                           pipe_valid;
    logic                           hold_pipe;
    logic                           ram_req_type;

    // incoming item survives only if not flushed
    assign pipe_valid = valid_ex_i && !flush_i;
    assign hold_pipe = !allow_in_wb_i || hold_i;

    assign ram_req_type = mem_read_o || mem_write_o;
    assign ram_req_o = valid_q && ram_req_type && allow_in_wb_i && !hold_i;

    // memory ops go once the ram takes the request, others pass straight on
    assign ready_go_mem_o = (ram_req_o && mem_addr_ok_i) || !ram_req_type;

    // empty, or the current item leaves this cycle
    assign allow_in_mem_o = !valid_q || (ready_go_mem_o && !hold_pipe);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_mem_o)
        begin
            valid_q <= pipe_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_valid && allow_in_mem_o)
        begin
            address_q <= mem_address_i;
            wdata_q   <= mem_write_data_i;
            control_q <= control_flow_ex_i;
            rd_q      <= rd_ex_i;
            funct3_q  <= funct3_i;
        end
    end

    // ram only sees the low byte-address bits
    assign mem_address_o = address_q[lsu_pkg::bus_width-1:0];
    assign mem_write_data_o = wdata_q;
    assign rd_mem_o = rd_q;
    assign funct3_o = funct3_q;
    assign valid_mem_o = valid_q;

    // control qualified by valid so a stale field never fires
    assign mem_read_o = control_q[lsu_pkg::ctl_read] && valid_q;
    assign mem_write_o = control_q[lsu_pkg::ctl_write] && valid_q;
    assign regwrite_o = control_q[lsu_pkg::ctl_regwrite] && valid_q;

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              issue_valid_i,
    input  wire logic                              issue_load_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_base_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_offset_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_wdata_i,
    input  wire logic [lsu_pkg::rd_width-1:0]      issue_rd_i,
    input  wire logic [lsu_pkg::f3_width-1:0]      issue_funct3_i,
    input  wire logic                              allow_in_mem_i,
    output logic                                   issue_ready_o,
    output logic                                   valid_ex_o,
    output logic      [lsu_pkg::data_width-1:0]    mem_address_o,
    output logic      [lsu_pkg::data_width-1:0]    mem_wdata_o,
    output logic      [lsu_pkg::ctl_width-1:0]     control_o,
    output logic      [lsu_pkg::rd_width-1:0]      rd_o,
    output logic      [lsu_pkg::f3_width-1:0]      funct3_o
);

    logic                           valid_q;
    logic                           load_q;
    logic [lsu_pkg::data_width-1:0] base_q;
    logic [lsu_pkg::data_width-1:0] offset_q;
    logic [lsu_pkg::data_width-1:0] wdata_q;
    logic [lsu_pkg::rd_width-1:0]   rd_q;
    logic [lsu_pkg::f3_width-1:0]   funct3_q;

    // stage empties when ex_mem takes the item or the item is flushed
    assign issue_ready_o = !valid_q || allow_in_mem_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (issue_ready_o)
        begin
            valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue_valid_i && issue_ready_o)
        begin
            load_q   <= issue_load_i;
            base_q   <= issue_base_i;
            offset_q <= issue_offset_i;
            wdata_q  <= issue_wdata_i;
            rd_q     <= issue_rd_i;
            funct3_q <= issue_funct3_i;
        end
    end

    // effective address
    assign mem_address_o = base_q + offset_q;

    always_comb
    begin
        control_o = '0;
        control_o[lsu_pkg::ctl_read] = load_q;
        control_o[lsu_pkg::ctl_write] = !load_q;
        control_o[lsu_pkg::ctl_regwrite] = load_q;
    end

    // copy narrow store data onto every lane, ram picks lanes by address
    always_comb
    begin
        case (funct3_q)
            lsu_pkg::f3_byte, lsu_pkg::f3_byte_u:
                mem_wdata_o = {lsu_pkg::bytes_per_word{wdata_q[7:0]}};
            lsu_pkg::f3_half, lsu_pkg::f3_half_u:
                mem_wdata_o = {(lsu_pkg::bytes_per_word / 2){wdata_q[15:0]}};
            default:
                mem_wdata_o = wdata_q;
        endcase
    end

    assign valid_ex_o = valid_q;
    assign rd_o = rd_q;
    assign funct3_o = funct3_q;

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // datapath widths
    localparam int data_width = 32;
    localparam int rd_width = 5;
    localparam int f3_width = 3;

    // byte address into the data ram, 4 KiB
    localparam int bus_width = 12;
    localparam int bytes_per_word = data_width / 8;
    localparam int ram_words = 2 ** (bus_width - 2);

    // control field layout
    // bit 1 is reserved and kept at zero
    localparam int ctl_width = 4;
    localparam int ctl_read = 3;
    localparam int ctl_write = 2;
    localparam int ctl_regwrite = 0;

    // access size, rv32 load/store funct3
    localparam logic [f3_width-1:0] f3_byte = 3'd0;
    localparam logic [f3_width-1:0] f3_half = 3'd1;
    localparam logic [f3_width-1:0] f3_word = 3'd2;
    localparam logic [f3_width-1:0] f3_byte_u = 3'd4;
    localparam logic [f3_width-1:0] f3_half_u = 3'd5;

endpackage

`default_nettype wire

// File: lsu_top.sv
`default_nettype none

module lsu_top (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              issue_valid_i,
    input  wire logic                              issue_load_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_base_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_offset_i,
    input  wire logic [lsu_pkg::data_width-1:0]    issue_wdata_i,
    input  wire logic [lsu_pkg::rd_width-1:0]      issue_rd_i,
    input  wire logic [lsu_pkg::f3_width-1:0]      issue_funct3_i,
    input  wire logic                              flush_i,
    input  wire logic                              hold_i,
    input  wire logic                              wb_ready_i,
    output logic                                   issue_ready_o,
    output logic                                   wb_valid_o,
    output logic      [lsu_pkg::rd_width-1:0]      wb_rd_o,
    output logic      [lsu_pkg::data_width-1:0]    wb_data_o
);

    // execute to ex_mem
    logic                           valid_ex;
    logic [lsu_pkg::data_width-1:0] ex_address;
    logic [lsu_pkg::data_width-1:0] ex_wdata;
    logic [lsu_pkg::ctl_width-1:0]  ex_control;
    logic [lsu_pkg::rd_width-1:0]   ex_rd;
    logic [lsu_pkg::f3_width-1:0]   ex_funct3;
    logic                           allow_in_mem;

    // ex_mem to memory/writeback
    logic                           ram_req;
    logic [lsu_pkg::bus_width-1:0]  mem_address;
    logic [lsu_pkg::data_width-1:0] mem_wdata;
    logic                           mem_read;
    logic                           mem_write;
    logic                           regwrite;
    logic [lsu_pkg::rd_width-1:0]   mem_rd;
    logic [lsu_pkg::f3_width-1:0]   mem_funct3;
    logic                           valid_mem;
    logic                           ready_go_mem;
    logic                           mem_addr_ok;
    logic                           allow_in_wb;

    ex_stage u_ex_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid_i  (issue_valid_i),
        .issue_load_i   (issue_load_i),
        .issue_base_i   (issue_base_i),
        .issue_offset_i (issue_offset_i),
        .issue_wdata_i  (issue_wdata_i),
        .issue_rd_i     (issue_rd_i),
        .issue_funct3_i (issue_funct3_i),
        .allow_in_mem_i (allow_in_mem),
        .issue_ready_o  (issue_ready_o),
        .valid_ex_o     (valid_ex),
        .mem_address_o  (ex_address),
        .mem_wdata_o    (ex_wdata),
        .control_o      (ex_control),
        .rd_o           (ex_rd),
        .funct3_o       (ex_funct3)
    );

    ex_mem u_ex_mem (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush_i           (flush_i),
        .hold_i            (hold_i),
        .mem_addr_ok_i     (mem_addr_ok),
        .allow_in_wb_i     (allow_in_wb),
        .valid_ex_i        (valid_ex),
        .mem_address_i     (ex_address),
        .mem_write_data_i  (ex_wdata),
        .control_flow_ex_i (ex_control),
        .rd_ex_i           (ex_rd),
        .funct3_i          (ex_funct3),
        .ram_req_o         (ram_req),
        .mem_address_o     (mem_address),
        .mem_write_data_o  (mem_wdata),
        .mem_read_o        (mem_read),
        .mem_write_o       (mem_write),
        .regwrite_o        (regwrite),
        .rd_mem_o          (mem_rd),
        .funct3_o          (mem_funct3),
        .valid_mem_o       (valid_mem),
        .ready_go_mem_o    (ready_go_mem),
        .allow_in_mem_o    (allow_in_mem)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ram_req_i        (ram_req),
        .mem_address_i    (mem_address),
        .mem_write_data_i (mem_wdata),
        .mem_read_i       (mem_read),
        .mem_write_i      (mem_write),
        .regwrite_i       (regwrite),
        .rd_i             (mem_rd),
        .funct3_i         (mem_funct3),
        .valid_mem_i      (valid_mem),
        .ready_go_mem_i   (ready_go_mem),
        .wb_ready_i       (wb_ready_i),
        .mem_addr_ok_o    (mem_addr_ok),
        .allow_in_wb_o    (allow_in_wb),
        .wb_valid_o       (wb_valid_o),
        .wb_rd_o          (wb_rd_o),
        .wb_data_o        (wb_data_o)
    );

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              ram_req_i,
    input  wire logic [lsu_pkg::bus_width-1:0]     mem_address_i,
    input  wire logic [lsu_pkg::data_width-1:0]    mem_write_data_i,
    input  wire logic                              mem_read_i,
    input  wire logic                              mem_write_i,
    input  wire logic                              regwrite_i,
    input  wire logic [lsu_pkg::rd_width-1:0]      rd_i,
    input  wire logic [lsu_pkg::f3_width-1:0]      funct3_i,
    input  wire logic                              valid_mem_i,
    input  wire logic                              ready_go_mem_i,
    input  wire logic                              wb_ready_i,
    output logic                                   mem_addr_ok_o,
    output logic                                   allow_in_wb_o,
    output logic                                   wb_valid_o,
    output logic      [lsu_pkg::rd_width-1:0]      wb_rd_o,
    output logic      [lsu_pkg::data_width-1:0]    wb_data_o
);

    logic                           valid_q;
    logic                           load_q;
    logic                           regwrite_q;
    logic [lsu_pkg::rd_width-1:0]   rd_q;
    logic [lsu_pkg::f3_width-1:0]   funct3_q;
    logic [1:0]                     offset_q;
    logic [lsu_pkg::data_width-1:0] rdata;
    logic [lsu_pkg::data_width-1:0] load_data;
    logic [7:0]                     byte_sel;
    logic [15:0]                    half_sel;

    data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (ram_req_i),
        .we_i      (mem_write_i),
        .addr_i    (mem_address_i),
        .wdata_i   (mem_write_data_i),
        .funct3_i  (funct3_i),
        .addr_ok_o (mem_addr_ok_o),
        .rdata_o   (rdata)
    );

    // stores never wait on wb_ready_i, they drop out after one cycle
    assign allow_in_wb_o = !valid_q || !regwrite_q || wb_ready_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_wb_o)
        begin
            valid_q <= valid_mem_i && ready_go_mem_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid_mem_i && ready_go_mem_i && allow_in_wb_o)
        begin
            load_q     <= mem_read_i;
            regwrite_q <= regwrite_i;
            rd_q       <= rd_i;
            funct3_q   <= funct3_i;
            offset_q   <= mem_address_i[1:0];
        end
    end

    assign byte_sel = rdata[{offset_q, 3'b000} +: 8];
    assign half_sel = rdata[{offset_q[1], 4'b0000} +: 16];

    always_comb
    begin
        case (funct3_q)
            lsu_pkg::f3_byte:   load_data = {{(lsu_pkg::data_width-8){byte_sel[7]}}, byte_sel};
            lsu_pkg::f3_byte_u: load_data = {{(lsu_pkg::data_width-8){1'b0}}, byte_sel};
            lsu_pkg::f3_half:   load_data = {{(lsu_pkg::data_width-16){half_sel[15]}}, half_sel};
            lsu_pkg::f3_half_u: load_data = {{(lsu_pkg::data_width-16){1'b0}}, half_sel};
            default:            load_data = rdata;
        endcase
    end

    assign wb_valid_o = valid_q && regwrite_q;
    assign wb_rd_o = rd_q;
    assign wb_data_o = load_q ? load_data : '0;

endmodule

`default_nettype wire

// File: sources.f
lsu_pkg.sv
ex_stage.sv
ex_mem.sv
data_ram.sv
mem_wb_stage.sv
lsu_top.sv
tb_lsu.sv

// File: tb_lsu.sv
`default_nettype none

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half = 20;
    localparam logic [lsu_pkg::bus_width-1:0] region_base = 12'h200;
    localparam int region_words = 64;
    localparam int issue_limit = 100;
    localparam int drain_limit = 200;

    logic                           clk;
    logic                           rst_n;
    logic                           issue_valid_i;
    logic                           issue_load_i;
    logic [lsu_pkg::data_width-1:0] issue_base_i;
    logic [lsu_pkg::data_width-1:0] issue_offset_i;
    logic [lsu_pkg::data_width-1:0] issue_wdata_i;
    logic [lsu_pkg::rd_width-1:0]   issue_rd_i;
    logic [lsu_pkg::f3_width-1:0]   issue_funct3_i;
    logic                           flush_i;
    logic                           hold_i;
    logic                           wb_ready_i;
    logic                           issue_ready_o;
    logic                           wb_valid_o;
    logic [lsu_pkg::rd_width-1:0]   wb_rd_o;
    logic [lsu_pkg::data_width-1:0] wb_data_o;

    // byte image of the data ram as of store issue
    logic [7:0]                     shadow [2**lsu_pkg::bus_width];
    logic [lsu_pkg::data_width-1:0] exp_data_q [$];
    logic [lsu_pkg::rd_width-1:0]   exp_rd_q [$];
    logic [31:0]                    lfsr_q;
    bit                             bp_on;
    string                          test_name;

    lsu_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid_i  (issue_valid_i),
        .issue_load_i   (issue_load_i),
        .issue_base_i   (issue_base_i),
        .issue_offset_i (issue_offset_i),
        .issue_wdata_i  (issue_wdata_i),
        .issue_rd_i     (issue_rd_i),
        .issue_funct3_i (issue_funct3_i),
        .flush_i        (flush_i),
        .hold_i         (hold_i),
        .wb_ready_i     (wb_ready_i),
        .issue_ready_o  (issue_ready_o),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // right-shifting galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'hB4BC_D35C;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return val;
    endfunction

    function automatic logic [2:0] pick_size(input int idx);
        case (idx)
            0: return lsu_pkg::f3_byte;
            1: return lsu_pkg::f3_half;
            2: return lsu_pkg::f3_word;
            3: return lsu_pkg::f3_byte_u;
            default: return lsu_pkg::f3_half_u;
        endcase
    endfunction

    // low two funct3 bits give log2 of the access size
    task automatic model_store(input logic [11:0] addr, input logic [2:0] f3,
                               input logic [31:0] data);
        for (int i = 0; i < (1 << f3[1:0]); i++)
        begin
            shadow[addr + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] expected_load(input logic [11:0] addr,
                                                  input logic [2:0] f3);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = shadow[addr];
        b1 = shadow[addr + 1];
        b2 = shadow[addr + 2];
        b3 = shadow[addr + 3];
        case (f3)
            lsu_pkg::f3_byte:   return {{24{b0[7]}}, b0};
            lsu_pkg::f3_byte_u: return {24'b0, b0};
            lsu_pkg::f3_half:   return {{16{b1[7]}}, b1, b0};
            lsu_pkg::f3_half_u: return {16'b0, b1, b0};
            default:            return {b3, b2, b1, b0};
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out while %s in test %s", what, test_name);
        $display(">>> FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    // all input changes happen on the falling edge
    task automatic tick();
        @(negedge clk);
        if (bp_on)
        begin
            wb_ready_i = rand_bits(1);
            hold_i = rand_bits(1);
        end
    endtask

    task automatic issue_op(input logic load, input logic [11:0] addr, input logic [2:0] f3,
                            input logic [31:0] data, input logic [4:0] rd, input bit flushed);
        logic [31:0] base;
        int          waited;
        base = rand_bits(32);
        waited = 0;
        issue_valid_i = 1'b1;
        issue_load_i = load;
        issue_base_i = base;
        issue_offset_i = {20'b0, addr} - base;
        issue_wdata_i = data;
        issue_rd_i = rd;
        issue_funct3_i = f3;
        #1;
        while (!issue_ready_o)
        begin
            tick();
            #1;
            waited++;
            if (waited > issue_limit)
            begin
                timeout_fail("waiting for issue_ready_o");
            end
        end
        // taken at the coming rising edge
        if (load && !flushed)
        begin
            exp_data_q.push_back(expected_load(addr, f3));
            exp_rd_q.push_back(rd);
        end
        else if (!load)
        begin
            model_store(addr, f3, data);
        end
        tick();
        issue_valid_i = 1'b0;
        if (flushed)
        begin
            // drop the load as it moves into ex_mem
            flush_i = 1'b1;
            tick();
            flush_i = 1'b0;
        end
    endtask

    task automatic random_op(input bit narrow);
        logic       load;
        logic [2:0] f3;
        logic [7:0] offs;
        load = rand_bits(1);
        f3 = narrow ? pick_size(rand_bits(3) % 5) : lsu_pkg::f3_word;
        if (!load)
        begin
            f3 = f3 & 3'b011;
        end
        offs = (rand_bits(8) >> f3[1:0]) << f3[1:0];
        issue_op(load, region_base + offs, f3, rand_bits(32), rand_bits(5), 1'b0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0)
        begin
            tick();
            waited++;
            if (waited > drain_limit)
            begin
                timeout_fail("waiting for load results");
            end
        end
    endtask

    // writeback compare, sampled just after the falling edge
    initial
    begin
        forever
        begin
            @(negedge clk);
            #2;
            if (wb_valid_o === 1'b1 && wb_ready_i === 1'b1)
            begin
                if (exp_data_q.size() == 0)
                begin
                    $display("writeback of rd %0d arrived with no load outstanding", wb_rd_o);
                    $display(">>> FAIL");
                    $fatal(1, "stopping on extra writeback");
                end
                else
                begin
                    check({test_name, " rd"}, exp_rd_q.pop_front(), wb_rd_o);
                    check({test_name, " data"}, exp_data_q.pop_front(), wb_data_o);
                end
            end
        end
    end

    initial
    begin
        lfsr_q = 32'd12;
        bp_on = 1'b0;
        test_name = "reset";
        rst_n = 1'b0;
        issue_valid_i = 1'b0;
        issue_load_i = 1'b0;
        issue_base_i = '0;
        issue_offset_i = '0;
        issue_wdata_i = '0;
        issue_rd_i = '0;
        issue_funct3_i = '0;
        flush_i = 1'b0;
        hold_i = 1'b0;
        wb_ready_i = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check("reset issue_ready", 1, issue_ready_o);
        check("reset wb_valid", 0, wb_valid_o);
        tick();

        // back-to-back word stores make the ram refuse every other cycle
        test_name = "fill";
        for (int i = 0; i < region_words; i++)
        begin
            issue_op(1'b0, region_base + 4*i, lsu_pkg::f3_word, rand_bits(32), 0, 1'b0);
        end

        test_name = "word";
        repeat (40) random_op(1'b0);
        drain();

        test_name = "narrow";
        repeat (80) random_op(1'b1);
        drain();

        test_name = "backpressure";
        bp_on = 1'b1;
        repeat (100) random_op(1'b1);
        drain();
        bp_on = 1'b0;
        wb_ready_i = 1'b1;
        hold_i = 1'b0;

        // fence load empties the pipe before the flush
        test_name = "flush";
        issue_op(1'b1, region_base, lsu_pkg::f3_word, 0, 5'd3, 1'b0);
        drain();
        issue_op(1'b1, region_base + 8, lsu_pkg::f3_word, 0, 5'd31, 1'b1);
        issue_op(1'b1, region_base + 12, lsu_pkg::f3_word, 0, 5'd9, 1'b0);
        drain();

        test_name = "readback";
        for (int i = 0; i < region_words; i++)
        begin
            issue_op(1'b1, region_base + 4*i, lsu_pkg::f3_word, 0, i[4:0], 1'b0);
        end
        drain();
        // last result taken, nothing may be left behind
        check("idle wb_valid", 0, wb_valid_o);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
